// ==== verilog/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] regIndex_t;
	typedef logic [4:0] flags_t;

	// PSR bit positions
	localparam int flagCarry = 0;
	localparam int flagLow = 1;
	localparam int flagFlag = 2; // Signed overflow
	localparam int flagZero = 3;
	localparam int flagNeg = 4;

	typedef enum logic [1:0] {
		stateFetch = 2'b00,
		stateDecode = 2'b01,
		stateExecute = 2'b10,
		stateWriteBack = 2'b11
	} state_t;

	typedef enum logic [3:0] {
		opRType = 4'b0000,
		opAndi = 4'b0001,
		opOri = 4'b0010,
		opXori = 4'b0011,
		opSpecial = 4'b0100, // LOAD, STOR, Jcond, JAL
		opAddi = 4'b0101,
		opLshi = 4'b1000,
		opSubi = 4'b1001,
		opCmpi = 4'b1011,
		opBcond = 4'b1100,
		opMovi = 4'b1101,
		opLui = 4'b1111
	} opcode_t;

	// Secondary code in bits 7:4, meaning depends on the major opcode
	typedef logic [3:0] extCode_t;
	localparam extCode_t extAnd = 4'b0001;
	localparam extCode_t extOr = 4'b0010;
	localparam extCode_t extXor = 4'b0011;
	localparam extCode_t extLsh = 4'b0100;
	localparam extCode_t extAdd = 4'b0101;
	localparam extCode_t extSub = 4'b1001;
	localparam extCode_t extCmp = 4'b1011;
	localparam extCode_t extMov = 4'b1101;
	localparam extCode_t extLoad = 4'b0000;
	localparam extCode_t extStor = 4'b0100;
	localparam extCode_t extJal = 4'b1000;
	localparam extCode_t extJcond = 4'b1100;

	typedef enum logic [3:0] {
		condEq, condNe, condCs, condCc,
		condHi, condLs, condGt, condLe,
		condFs, condFc, condLo, condHs,
		condLt, condGe, condUc, condNv
	} cond_t;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluMov, aluLsh, aluLui
	} aluOp_t;

	typedef enum logic [1:0] {
		immShift4, // Low nibble, sign extended
		immSigned8,
		immZero8,
		immUpper // Low byte moved to the upper half
	} immType_t;

	typedef enum logic [1:0] {
		wbAlu = 2'b00,
		wbMemory = 2'b01,
		wbReturn = 2'b10
	} wbSource_t;

endpackage

`default_nettype wire

// ==== verilog/controlBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface controlBus;

	cpuPkg::word_t instruction; // IR contents
	cpuPkg::flags_t flags; // PSR
	logic fetch;
	logic irEn;
	logic pcEn;
	logic pcSet; // Take branch target instead of PC+1
	logic rfWe;
	logic psrEn;
	logic memWe;
	cpuPkg::wbSource_t wbSource;
	logic operandImm; // B operand from the immediate
	cpuPkg::immType_t immType;
	cpuPkg::aluOp_t aluOp;
	logic baseIsPc;

	modport fsm (
		input instruction, flags,
		output fetch, irEn, pcEn, pcSet, rfWe, psrEn, memWe,
		output wbSource, operandImm, immType, aluOp, baseIsPc
	);

	modport datapath (
		output instruction, flags,
		input fetch, irEn, pcEn, pcSet, rfWe, psrEn, memWe,
		input wbSource, operandImm, immType, aluOp, baseIsPc
	);

endinterface

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluOp_t op,
	output cpuPkg::word_t result,
	output cpuPkg::flags_t flagsOut
);

	logic [16:0] sum;
	logic [16:0] diff;
	cpuPkg::word_t negAmount;
	cpuPkg::word_t shifted;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	// Negative amount shifts right
	assign negAmount = ~b + 16'd1;
	assign shifted = b[15] ? (a >> negAmount) : (a << b);

	always_comb begin
		unique case (op)
			cpuPkg::aluAdd: result = sum[15:0];
			cpuPkg::aluSub: result = diff[15:0];
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr: result = a | b;
			cpuPkg::aluXor: result = a ^ b;
			cpuPkg::aluMov: result = b;
			cpuPkg::aluLsh: result = shifted;
			cpuPkg::aluLui: result = {b[15:8], a[7:0]}; // Keep low byte of dest
		endcase
	end

	always_comb begin
		flagsOut = '0;
		flagsOut[cpuPkg::flagLow] = b < a; // Unsigned compare
		flagsOut[cpuPkg::flagNeg] = $signed(b) < $signed(a);
		flagsOut[cpuPkg::flagZero] = a == b;
		if (op == cpuPkg::aluAdd) begin
			flagsOut[cpuPkg::flagCarry] = sum[16];
			flagsOut[cpuPkg::flagFlag] = (a[15] == b[15]) && (sum[15] != a[15]);
		end
		else if (op == cpuPkg::aluSub) begin
			flagsOut[cpuPkg::flagCarry] = diff[16]; // Borrow
			flagsOut[cpuPkg::flagFlag] = (a[15] != b[15]) && (diff[15] != a[15]);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input logic clock,
	input logic we,
	input cpuPkg::regIndex_t writeIndex,
	input cpuPkg::regIndex_t readIndexA,
	input cpuPkg::regIndex_t readIndexB,
	input cpuPkg::word_t writeData,
	output cpuPkg::word_t readDataA,
	output cpuPkg::word_t readDataB
);

	cpuPkg::word_t regs [0:15];

	always_ff @(posedge clock) begin
		if (we)
			regs[writeIndex] <= writeData;
	end

	assign readDataA = regs[readIndexA];
	assign readDataB = regs[readIndexB];

	// Index comes from the IR loaded two cycles earlier
	assert property (@(posedge clock) we |-> !$isunknown(writeIndex));

endmodule

`default_nettype wire

// ==== verilog/controlFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
	input logic clock,
	input logic reset,
	controlBus.fsm bus
);

	cpuPkg::state_t state;
	cpuPkg::state_t nextState;
	cpuPkg::opcode_t opcode;
	cpuPkg::extCode_t extCode;
	cpuPkg::cond_t cond;
	logic writesReg;
	logic setsFlags;
	logic isStore;
	logic isJump; // Jcond or Bcond
	logic isJal;
	logic condTrue;

	assign opcode = cpuPkg::opcode_t'(bus.instruction[15:12]);
	assign extCode = bus.instruction[7:4];
	assign cond = cpuPkg::cond_t'(bus.instruction[11:8]);

	always_ff @(posedge clock) begin
		if (!reset)
			state <= cpuPkg::stateFetch;
		else
			state <= nextState;
	end

	// Instruction decode, independent of state
	always_comb begin
		bus.aluOp = cpuPkg::aluMov;
		bus.operandImm = 1'b1;
		bus.immType = cpuPkg::immZero8;
		bus.wbSource = cpuPkg::wbAlu;
		bus.baseIsPc = 1'b0;
		writesReg = 1'b1;
		setsFlags = 1'b0;
		isStore = 1'b0;
		isJump = 1'b0;
		isJal = 1'b0;
		case (opcode)
			cpuPkg::opRType: begin
				bus.operandImm = 1'b0;
				case (extCode)
					cpuPkg::extAnd: bus.aluOp = cpuPkg::aluAnd;
					cpuPkg::extOr: bus.aluOp = cpuPkg::aluOr;
					cpuPkg::extXor: bus.aluOp = cpuPkg::aluXor;
					cpuPkg::extLsh: bus.aluOp = cpuPkg::aluLsh;
					cpuPkg::extMov: bus.aluOp = cpuPkg::aluMov;
					cpuPkg::extAdd: begin
						bus.aluOp = cpuPkg::aluAdd;
						setsFlags = 1'b1;
					end
					cpuPkg::extSub: begin
						bus.aluOp = cpuPkg::aluSub;
						setsFlags = 1'b1;
					end
					cpuPkg::extCmp: begin
						bus.aluOp = cpuPkg::aluSub;
						setsFlags = 1'b1;
						writesReg = 1'b0; // Flags only
					end
					default: writesReg = 1'b0;
				endcase
			end
			cpuPkg::opAndi: bus.aluOp = cpuPkg::aluAnd;
			cpuPkg::opOri: bus.aluOp = cpuPkg::aluOr;
			cpuPkg::opXori: bus.aluOp = cpuPkg::aluXor;
			cpuPkg::opMovi: bus.aluOp = cpuPkg::aluMov;
			cpuPkg::opAddi, cpuPkg::opSubi, cpuPkg::opCmpi: begin
				bus.aluOp = (opcode == cpuPkg::opAddi) ? cpuPkg::aluAdd : cpuPkg::aluSub;
				bus.immType = cpuPkg::immSigned8;
				setsFlags = 1'b1;
				writesReg = (opcode != cpuPkg::opCmpi);
			end
			cpuPkg::opLshi: begin
				bus.aluOp = cpuPkg::aluLsh;
				bus.immType = cpuPkg::immShift4;
			end
			cpuPkg::opLui: begin
				bus.aluOp = cpuPkg::aluLui;
				bus.immType = cpuPkg::immUpper;
			end
			cpuPkg::opBcond: begin
				bus.immType = cpuPkg::immSigned8; // Displacement
				bus.baseIsPc = 1'b1;
				isJump = 1'b1;
				writesReg = 1'b0;
			end
			cpuPkg::opSpecial: begin
				writesReg = 1'b0;
				case (extCode)
					cpuPkg::extLoad: begin
						bus.wbSource = cpuPkg::wbMemory;
						writesReg = 1'b1;
					end
					cpuPkg::extStor: isStore = 1'b1;
					cpuPkg::extJal: begin
						bus.wbSource = cpuPkg::wbReturn; // Link gets PC+1
						writesReg = 1'b1;
						isJal = 1'b1;
					end
					cpuPkg::extJcond: isJump = 1'b1;
					default: ;
				endcase
			end
			default: writesReg = 1'b0; // Unused opcodes act as NOP
		endcase
	end

	always_comb begin
		unique case (cond)
			cpuPkg::condEq: condTrue = bus.flags[cpuPkg::flagZero];
			cpuPkg::condNe: condTrue = !bus.flags[cpuPkg::flagZero];
			cpuPkg::condCs: condTrue = bus.flags[cpuPkg::flagCarry];
			cpuPkg::condCc: condTrue = !bus.flags[cpuPkg::flagCarry];
			cpuPkg::condHi: condTrue = bus.flags[cpuPkg::flagLow];
			cpuPkg::condLs: condTrue = !bus.flags[cpuPkg::flagLow];
			cpuPkg::condGt: condTrue = bus.flags[cpuPkg::flagNeg];
			cpuPkg::condLe: condTrue = !bus.flags[cpuPkg::flagNeg];
			cpuPkg::condFs: condTrue = bus.flags[cpuPkg::flagFlag];
			cpuPkg::condFc: condTrue = !bus.flags[cpuPkg::flagFlag];
			cpuPkg::condLo: condTrue = !bus.flags[cpuPkg::flagLow] && !bus.flags[cpuPkg::flagZero];
			cpuPkg::condHs: condTrue = bus.flags[cpuPkg::flagLow] || bus.flags[cpuPkg::flagZero];
			cpuPkg::condLt: condTrue = !bus.flags[cpuPkg::flagNeg] && !bus.flags[cpuPkg::flagZero];
			cpuPkg::condGe: condTrue = bus.flags[cpuPkg::flagNeg] || bus.flags[cpuPkg::flagZero];
			cpuPkg::condUc: condTrue = 1'b1;
			cpuPkg::condNv: condTrue = 1'b0;
		endcase
	end

	// Enables by state
	always_comb begin
		bus.fetch = 1'b0;
		bus.irEn = 1'b0;
		bus.pcEn = 1'b0;
		bus.pcSet = 1'b0;
		bus.rfWe = 1'b0;
		bus.psrEn = 1'b0;
		bus.memWe = 1'b0;
		nextState = cpuPkg::stateFetch;
		unique case (state)
			cpuPkg::stateFetch: begin
				bus.fetch = 1'b1;
				nextState = cpuPkg::stateDecode;
			end
			cpuPkg::stateDecode: begin
				bus.irEn = 1'b1; // Read data arrives this cycle
				nextState = cpuPkg::stateExecute;
			end
			cpuPkg::stateExecute: begin
				bus.psrEn = setsFlags;
				bus.memWe = isStore;
				nextState = cpuPkg::stateWriteBack;
			end
			cpuPkg::stateWriteBack: begin
				bus.rfWe = writesReg;
				bus.pcEn = 1'b1;
				bus.pcSet = isJal || (isJump && condTrue);
			end
		endcase
	end

	assert property (@(posedge clock) disable iff (!reset)
		bus.memWe |-> state == cpuPkg::stateExecute);

	assert property (@(posedge clock) disable iff (!reset)
		!(bus.rfWe && bus.memWe));

	// Every instruction ends in exactly four cycles
	assert property (@(posedge clock) disable iff (!reset)
		state == cpuPkg::stateWriteBack |=> state == cpuPkg::stateFetch);

endmodule

`default_nettype wire

// ==== verilog/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input logic clock,
	input logic reset,
	controlBus.datapath bus,
	input cpuPkg::word_t memReadData,
	output cpuPkg::word_t memAddr,
	output cpuPkg::word_t memWriteData,
	output logic memWe,
	output logic fetchStrobe
);

	cpuPkg::word_t pc;
	cpuPkg::word_t pcPlusOne;
	cpuPkg::word_t ir;
	cpuPkg::flags_t psr;
	cpuPkg::regIndex_t destIndex;
	cpuPkg::regIndex_t srcIndex;
	cpuPkg::word_t destData;
	cpuPkg::word_t srcData;
	cpuPkg::word_t immValue;
	cpuPkg::word_t operandB;
	cpuPkg::word_t aluResult;
	cpuPkg::flags_t aluFlags;
	cpuPkg::word_t writeData;
	cpuPkg::word_t branchTarget;

	assign destIndex = ir[11:8];
	assign srcIndex = ir[3:0]; // Also address and jump target register

	assign pcPlusOne = pc + 16'd1;
	assign branchTarget = bus.baseIsPc ? pc + immValue : srcData;

	always_ff @(posedge clock) begin
		if (!reset)
			pc <= '0;
		else if (bus.pcEn)
			pc <= bus.pcSet ? branchTarget : pcPlusOne;
	end

	always_ff @(posedge clock) begin
		if (bus.irEn)
			ir <= memReadData;
	end

	always_ff @(posedge clock) begin
		if (!reset)
			psr <= '0;
		else if (bus.psrEn)
			psr <= aluFlags;
	end

	always_comb begin
		unique case (bus.immType)
			cpuPkg::immShift4: immValue = {{12{ir[3]}}, ir[3:0]};
			cpuPkg::immSigned8: immValue = {{8{ir[7]}}, ir[7:0]};
			cpuPkg::immZero8: immValue = {8'h00, ir[7:0]};
			cpuPkg::immUpper: immValue = {ir[7:0], 8'h00};
		endcase
	end

	assign operandB = bus.operandImm ? immValue : srcData;

	always_comb begin
		case (bus.wbSource)
			cpuPkg::wbMemory: writeData = memReadData; // LOAD data from execute address
			cpuPkg::wbReturn: writeData = pcPlusOne;
			default: writeData = aluResult;
		endcase
	end

	alu alu_inst (
		.a(destData),
		.b(operandB),
		.op(bus.aluOp),
		.result(aluResult),
		.flagsOut(aluFlags)
	);

	registerFile registerFile_inst (
		.clock(clock),
		.we(bus.rfWe),
		.writeIndex(destIndex),
		.readIndexA(srcIndex),
		.readIndexB(destIndex),
		.writeData(writeData),
		.readDataA(srcData),
		.readDataB(destData)
	);

	assign bus.instruction = ir;
	assign bus.flags = psr;

	assign memAddr = bus.fetch ? pc : srcData;
	assign memWriteData = destData; // STOR source sits in the dest field
	assign memWe = bus.memWe;
	assign fetchStrobe = bus.fetch;

endmodule

`default_nettype wire

// ==== verilog/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
	input logic clock,
	input logic reset,
	input cpuPkg::word_t memReadData,
	output cpuPkg::word_t memAddr,
	output cpuPkg::word_t memWriteData,
	output logic memWe,
	output logic fetchStrobe
);

	controlBus bus ();

	controlFsm controlFsm_inst (
		.clock(clock),
		.reset(reset),
		.bus(bus)
	);

	// Memory is one synchronous-read port outside the core
	datapath datapath_inst (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWe(memWe),
		.fetchStrobe(fetchStrobe)
	);

endmodule

`default_nettype wire

// ==== tb/cpuChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuChecker (
	input logic clock,
	input logic reset,
	input logic fetchStrobe,
	input cpuPkg::word_t memAddr,
	input cpuPkg::word_t memWriteData,
	input logic memWe,
	input logic [95:0] testName,
	input logic expectStore, // Store row, otherwise a fetch row
	input int seqFetches,
	input cpuPkg::word_t expectAddr,
	input cpuPkg::word_t expectData,
	output logic done,
	output int errorCount,
	output int checkCount
);

	int fetchIndex;
	int sinceFetch; // Cycles since the last fetch strobe

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	task automatic compare(input string what, input cpuPkg::word_t expected,
		input cpuPkg::word_t actual);
		if (expected !== actual) begin
			$display("mismatch %0s %0s: expected %h, actual %h", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	always @(posedge clock) begin
		if (!reset) begin
			done <= 1'b0;
			fetchIndex <= 0;
			sinceFetch <= 0;
		end
		else begin
			sinceFetch <= fetchStrobe ? 1 : sinceFetch + 1;
			if (fetchStrobe) begin
				fetchIndex <= fetchIndex + 1;
				if (fetchIndex > 0 && sinceFetch != 4) begin
					$display("test %0s: fetch strobes came %0d cycles apart instead of 4",
						testName, sinceFetch);
					errorCount++;
				end
			end
			if (!done) begin
				if (fetchStrobe && fetchIndex < seqFetches)
					compare("fetch address", fetchIndex[15:0], memAddr);
				if (fetchStrobe && !expectStore && fetchIndex == seqFetches) begin
					compare("next fetch", expectAddr, memAddr);
					checkCount++;
					done <= 1'b1;
				end
				if (memWe && expectStore) begin
					compare("store address", expectAddr, memAddr);
					compare("store data", expectData, memWriteData);
					checkCount++;
					done <= 1'b1;
				end
				else if (memWe) begin
					$display("test %0s: memory write where only a jump was expected", testName);
					errorCount++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

	localparam int maxRows = 40;
	localparam int timeoutCycles = 100;

	logic clock;
	logic reset;
	cpuPkg::word_t memReadData;
	cpuPkg::word_t memAddr;
	cpuPkg::word_t memWriteData;
	logic memWe;
	logic fetchStrobe;

	cpuPkg::word_t mem [0:255];
	logic [7:0] readAddr;

	// One row per test
	logic [95:0] names [0:maxRows-1];
	cpuPkg::word_t programs [0:maxRows-1][0:7];
	logic storeRows [0:maxRows-1];
	int seqCounts [0:maxRows-1]; // Leading fetches that must be sequential
	cpuPkg::word_t expAddrs [0:maxRows-1];
	cpuPkg::word_t expDatas [0:maxRows-1];
	int rowCount;
	int emitIndex;
	cpuPkg::word_t loadValue; // LOAD table word at 8'hC0
	int timeouts;

	logic [95:0] testName;
	logic expectStore;
	int seqFetches;
	cpuPkg::word_t expectAddr;
	cpuPkg::word_t expectData;
	logic done;
	int errorCount;
	int checkCount;

	cpuTop cpuTop_inst (
		.clock(clock),
		.reset(reset),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWe(memWe),
		.fetchStrobe(fetchStrobe)
	);

	cpuChecker cpuChecker_inst (
		.clock(clock),
		.reset(reset),
		.fetchStrobe(fetchStrobe),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWe(memWe),
		.testName(testName),
		.expectStore(expectStore),
		.seqFetches(seqFetches),
		.expectAddr(expectAddr),
		.expectData(expectData),
		.done(done),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock) begin
		readAddr <= memAddr[7:0];
		if (memWe)
			mem[memAddr[7:0]] <= memWriteData;
	end

	always @(negedge clock)
		memReadData <= mem[readAddr]; // Data one cycle after the address

	function automatic logic condHolds(input logic [3:0] cond, input cpuPkg::word_t a,
		input cpuPkg::word_t b);
		logic [16:0] diff;
		logic carry;
		logic low;
		logic neg;
		logic zero;
		logic over;
		diff = {1'b0, a} - {1'b0, b};
		carry = diff[16]; // Borrow of a - b
		low = b < a;
		neg = $signed(b) < $signed(a);
		zero = a == b;
		over = (a[15] != b[15]) && (diff[15] != a[15]);
		case (cond)
			cpuPkg::condEq: return zero;
			cpuPkg::condNe: return !zero;
			cpuPkg::condCs: return carry;
			cpuPkg::condCc: return !carry;
			cpuPkg::condHi: return low;
			cpuPkg::condLs: return !low;
			cpuPkg::condGt: return neg;
			cpuPkg::condLe: return !neg;
			cpuPkg::condFs: return over;
			cpuPkg::condFc: return !over;
			cpuPkg::condLo: return !low && !zero;
			cpuPkg::condHs: return low || zero;
			cpuPkg::condLt: return !neg && !zero;
			cpuPkg::condGe: return neg || zero;
			cpuPkg::condUc: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Positive amount shifts left, negative shifts right
	function automatic cpuPkg::word_t shiftBy(input cpuPkg::word_t value,
		input cpuPkg::word_t amount);
		if (amount[15])
			return value >> (16'd0 - amount);
		return value << amount;
	endfunction

	task automatic emit(input cpuPkg::word_t w);
		programs[rowCount][emitIndex] = w;
		emitIndex++;
	endtask

	task automatic setReg(input logic [3:0] r, input cpuPkg::word_t v);
		emit({cpuPkg::opMovi, r, v[7:0]});
		emit({cpuPkg::opLui, r, v[15:8]});
	endtask

	task automatic startRow(input logic [95:0] name);
		names[rowCount] = name;
		emitIndex = 0;
		for (int i = 0; i < 8; i++)
			programs[rowCount][i] = '0; // NOP
	endtask

	task automatic endRow(input logic isStore, input int seq, input cpuPkg::word_t addr,
		input cpuPkg::word_t data);
		storeRows[rowCount] = isStore;
		seqCounts[rowCount] = seq;
		expAddrs[rowCount] = addr;
		expDatas[rowCount] = data;
		rowCount++;
	endtask

	// r1 = x, r2 = y, one operation on r1, then store r1 to 8'h80
	task automatic aluRow(input logic [95:0] name, input cpuPkg::word_t opWord,
		input cpuPkg::word_t x, input cpuPkg::word_t y, input cpuPkg::word_t expected);
		startRow(name);
		setReg(4'd1, x);
		setReg(4'd2, y);
		emit(opWord);
		emit({cpuPkg::opMovi, 4'd5, 8'h80});
		emit({cpuPkg::opSpecial, 4'd1, cpuPkg::extStor, 4'd5});
		endRow(1'b1, 7, 16'h0080, expected);
	endtask

	task automatic buildTable;
		cpuPkg::word_t x;
		cpuPkg::word_t y;
		cpuPkg::word_t immS;
		cpuPkg::word_t amount;
		logic [7:0] imm;
		logic [7:0] digit;
		logic [3:0] cond;
		rowCount = 0;
		x = $urandom;
		y = $urandom;
		imm = $urandom;
		immS = {{8{imm[7]}}, imm};
		aluRow("movi", {cpuPkg::opMovi, 4'd1, imm}, x, y, {8'h00, imm});
		aluRow("addi", {cpuPkg::opAddi, 4'd1, imm}, x, y, x + immS);
		aluRow("subi", {cpuPkg::opSubi, 4'd1, imm}, x, y, x - immS);
		aluRow("andi", {cpuPkg::opAndi, 4'd1, imm}, x, y, x & {8'h00, imm});
		aluRow("ori", {cpuPkg::opOri, 4'd1, imm}, x, y, x | {8'h00, imm});
		aluRow("xori", {cpuPkg::opXori, 4'd1, imm}, x, y, x ^ {8'h00, imm});
		aluRow("lui", {cpuPkg::opLui, 4'd1, imm}, x, y, {imm, x[7:0]});
		aluRow("lshi", {cpuPkg::opLshi, 4'd1, 4'h0, imm[3:0]}, x, y,
			shiftBy(x, {{12{imm[3]}}, imm[3:0]}));
		aluRow("add", {cpuPkg::opRType, 4'd1, cpuPkg::extAdd, 4'd2}, x, y, x + y);
		aluRow("sub", {cpuPkg::opRType, 4'd1, cpuPkg::extSub, 4'd2}, x, y, x - y);
		aluRow("and", {cpuPkg::opRType, 4'd1, cpuPkg::extAnd, 4'd2}, x, y, x & y);
		aluRow("or", {cpuPkg::opRType, 4'd1, cpuPkg::extOr, 4'd2}, x, y, x | y);
		aluRow("xor", {cpuPkg::opRType, 4'd1, cpuPkg::extXor, 4'd2}, x, y, x ^ y);
		aluRow("mov", {cpuPkg::opRType, 4'd1, cpuPkg::extMov, 4'd2}, x, y, y);
		amount = ($urandom % 31) - 15;
		aluRow("lsh", {cpuPkg::opRType, 4'd1, cpuPkg::extLsh, 4'd2}, x, amount,
			shiftBy(x, amount));

		startRow("load");
		emit({cpuPkg::opMovi, 4'd3, 8'hC0});
		emit({cpuPkg::opSpecial, 4'd1, cpuPkg::extLoad, 4'd3});
		emit({cpuPkg::opMovi, 4'd5, 8'h80});
		emit({cpuPkg::opSpecial, 4'd1, cpuPkg::extStor, 4'd5});
		endRow(1'b1, 4, 16'h0080, loadValue);

		for (int c = 0; c < 16; c++) begin
			cond = c[3:0];
			digit = 8'd48 + cond + ((cond > 9) ? 8'd39 : 8'd0);
			x = $urandom;
			imm = $urandom;
			y = (c % 2) ? {{8{imm[7]}}, imm} : cpuPkg::word_t'($urandom);
			if (c % 3 == 0)
				x = y; // Equal operands for the zero flag
			startRow({"jcond", digit});
			setReg(4'd1, x);
			setReg(4'd2, y);
			emit({cpuPkg::opMovi, 4'd3, 8'h40});
			if (c % 2)
				emit({cpuPkg::opCmpi, 4'd1, imm});
			else
				emit({cpuPkg::opRType, 4'd1, cpuPkg::extCmp, 4'd2});
			emit({cpuPkg::opSpecial, cond, cpuPkg::extJcond, 4'd3});
			endRow(1'b0, 7, condHolds(cond, x, y) ? 16'h0040 : 16'd7, '0);
		end

		for (int i = 0; i < 4; i++) begin
			x = $urandom;
			y = $urandom;
			imm = $urandom;
			cond = $urandom;
			if (i == 0)
				cond = cpuPkg::condUc;
			startRow({"bcond", 8'd48 + i[7:0]});
			setReg(4'd1, x);
			setReg(4'd2, y);
			emit({cpuPkg::opRType, 4'd1, cpuPkg::extCmp, 4'd2});
			emit({cpuPkg::opBcond, cond, imm}); // Sits at address 5
			endRow(1'b0, 6, condHolds(cond, x, y) ? 16'd5 + {{8{imm[7]}}, imm} : 16'd6, '0);
		end

		startRow("jal");
		emit({cpuPkg::opMovi, 4'd3, 8'h07});
		emit({cpuPkg::opMovi, 4'd5, 8'h80});
		emit({cpuPkg::opSpecial, 4'd4, cpuPkg::extJal, 4'd3});
		for (int i = 3; i < 7; i++)
			emit({cpuPkg::opSpecial, 4'd3, cpuPkg::extStor, 4'd5}); // Only on a wrong target
		emit({cpuPkg::opSpecial, 4'd4, cpuPkg::extStor, 4'd5});
		endRow(1'b1, 3, 16'h0080, 16'd3);
	endtask

	task automatic runRow(input int row);
		int waited;
		@(negedge clock);
		reset = 1'b0;
		repeat (2) @(negedge clock); // Let a store in flight finish
		for (int a = 0; a < 256; a++)
			mem[a] = '0;
		for (int a = 0; a < 8; a++)
			mem[a] = programs[row][a];
		mem[8'hC0] = loadValue;
		testName = names[row];
		expectStore = storeRows[row];
		seqFetches = seqCounts[row];
		expectAddr = expAddrs[row];
		expectData = expDatas[row];
		repeat (14) @(negedge clock);
		reset = 1'b1;
		waited = 0;
		while (!done && waited < timeoutCycles) begin
			@(negedge clock);
			waited++;
		end
		if (!done) begin
			$display("timeout: test %0s never reached its store or fetch", names[row]);
			timeouts++;
		end
	endtask

	initial begin
		reset = 1'b0;
		memReadData = '0;
		testName = '0;
		expectStore = 1'b0;
		seqFetches = 0;
		expectAddr = '0;
		expectData = '0;
		timeouts = 0;
		loadValue = $urandom(32'h181a304a);
		buildTable();
		for (int row = 0; row < rowCount; row++)
			runRow(row);
		$display("%0d tests, %0d checks, %0d errors, %0d timeouts", rowCount, checkCount,
			errorCount, timeouts);
		if (errorCount == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/cpuPkg.sv
verilog/controlBus.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/controlFsm.sv
verilog/datapath.sv
verilog/cpuTop.sv
tb/cpuChecker.sv
tb/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - verilog/cpuPkg.sv
  - verilog/controlBus.sv
  - verilog/alu.sv
  - verilog/registerFile.sv
  - verilog/controlFsm.sv
  - verilog/datapath.sv
  - verilog/cpuTop.sv
  - target: test
    files:
      - tb/cpuChecker.sv
      - tb/cpuTb.sv
